// File: rtl/cnn_settings.svh
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// side lengths in words
`define CNN_IMG_DIM 8
`define CNN_K_DIM 3
`define CNN_OUT_DIM 6

// data widths
`define CNN_PIX_W 8
`define CNN_ACC_W 20
`define CNN_RES_W 16

// region is chosen by address bits 31 to 28
`define CNN_REGION_MASK 32'hf000_0000
`define CNN_PIXEL_BASE 32'h1000_0000
`define CNN_WEIGHT_BASE 32'h2000_0000
`define CNN_BIAS_BASE 32'h3000_0000
`define CNN_CTRL_BASE 32'h4000_0000
`define CNN_RESULT_BASE 32'hd000_0000

`endif

// File: rtl/cnn_pkg.sv
package cnn_pkg;

	// target of a host write
	typedef enum logic [2:0]
	{
		region_none,
		region_pixel,
		region_weight,
		region_bias,
		region_ctrl
	} region_e;

	// engine sequencing
	typedef enum logic [1:0]
	{
		state_idle,
		state_accumulate,
		state_save
	} conv_state_e;

endpackage

// File: rtl/cnn_ifs.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

// decoder to local stores, one-cycle strobes
interface store_write_if;
	logic write_pixel;
	logic write_weight;
	logic write_bias;
	logic [$clog2(`CNN_IMG_DIM*`CNN_IMG_DIM)-1:0] write_addr;
	logic [`CNN_RES_W-1:0] write_data;

	modport source (
		output write_pixel, write_weight, write_bias, write_addr, write_data
	);

	modport sink (
		input write_pixel, write_weight, write_bias, write_addr, write_data
	);
endinterface

// engine to result memory
interface result_save_if;
	logic save_enable;
	logic [$clog2(`CNN_OUT_DIM*`CNN_OUT_DIM)-1:0] save_index;
	logic [`CNN_RES_W-1:0] save_data;
	logic calculation_done;

	modport source (
		output save_enable, save_index, save_data, calculation_done
	);

	modport sink (
		input save_enable, save_index, save_data, calculation_done
	);
endinterface

// File: rtl/bus_write_decoder.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module bus_write_decoder (
	input logic clk,
	input logic rst,
	input logic [31:0] awaddr,
	input logic awvalid,
	input logic [31:0] wdata,
	input logic wvalid,
	store_write_if.source store,
	output logic start,
	output logic clear_interrupt
);
	localparam int addr_w = $clog2(`CNN_IMG_DIM*`CNN_IMG_DIM);

	cnn_pkg::region_e region;
	logic write_fire;

	// address and data must both be valid on the same edge
	assign write_fire = awvalid && wvalid;

	always_comb
	begin
		case (awaddr & `CNN_REGION_MASK)
			`CNN_PIXEL_BASE: region = cnn_pkg::region_pixel;
			`CNN_WEIGHT_BASE: region = cnn_pkg::region_weight;
			`CNN_BIAS_BASE: region = cnn_pkg::region_bias;
			`CNN_CTRL_BASE: region = cnn_pkg::region_ctrl;
			default: region = cnn_pkg::region_none;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			store.write_pixel <= 1'b0;
			store.write_weight <= 1'b0;
			store.write_bias <= 1'b0;
			start <= 1'b0;
			clear_interrupt <= 1'b0;
		end
		else
		begin
			store.write_pixel <= write_fire && (region == cnn_pkg::region_pixel);
			store.write_weight <= write_fire && (region == cnn_pkg::region_weight);
			store.write_bias <= write_fire && (region == cnn_pkg::region_bias);
			start <= write_fire && (region == cnn_pkg::region_ctrl) && wdata[0];
			clear_interrupt <= write_fire && (region == cnn_pkg::region_ctrl) && wdata[1];
		end
	end

	// word index in the low address bits
	always_ff @(posedge clk)
	begin
		store.write_addr <= awaddr[addr_w-1:0];
		store.write_data <= wdata[`CNN_RES_W-1:0];
	end

endmodule

// File: rtl/feature_store.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module feature_store (
	input logic clk,
	store_write_if.sink store,
	input logic [$clog2(`CNN_IMG_DIM)-1:0] pixel_row,
	input logic [$clog2(`CNN_IMG_DIM)-1:0] pixel_col,
	input logic [$clog2(`CNN_K_DIM*`CNN_K_DIM)-1:0] tap,
	output logic signed [`CNN_PIX_W-1:0] pixel_value,
	output logic signed [`CNN_PIX_W-1:0] weight_value,
	output logic signed [`CNN_RES_W-1:0] bias_value
);
	localparam int pixel_count = `CNN_IMG_DIM * `CNN_IMG_DIM;
	localparam int tap_count = `CNN_K_DIM * `CNN_K_DIM;
	localparam int tap_w = $clog2(tap_count);

	logic signed [`CNN_PIX_W-1:0] pixel_mem [pixel_count];
	logic signed [`CNN_PIX_W-1:0] weight_mem [tap_count];
	logic signed [`CNN_RES_W-1:0] bias_reg;

	always_ff @(posedge clk)
	begin
		if (store.write_pixel)
			pixel_mem[store.write_addr] <= store.write_data[`CNN_PIX_W-1:0];
		// taps beyond the kernel are dropped
		if (store.write_weight && (store.write_addr < tap_count))
			weight_mem[store.write_addr[tap_w-1:0]] <= store.write_data[`CNN_PIX_W-1:0];
		if (store.write_bias)
			bias_reg <= store.write_data;
	end

	// row-major, image side is a power of two
	assign pixel_value = pixel_mem[{pixel_row, pixel_col}];
	assign weight_value = weight_mem[tap];
	assign bias_value = bias_reg;

endmodule

// File: rtl/conv_engine.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module conv_engine (
	input logic clk,
	input logic rst,
	input logic start,
	input logic signed [`CNN_PIX_W-1:0] pixel_value,
	input logic signed [`CNN_PIX_W-1:0] weight_value,
	input logic signed [`CNN_RES_W-1:0] bias_value,
	output logic [$clog2(`CNN_IMG_DIM)-1:0] pixel_row,
	output logic [$clog2(`CNN_IMG_DIM)-1:0] pixel_col,
	output logic [$clog2(`CNN_K_DIM*`CNN_K_DIM)-1:0] tap,
	result_save_if.source result
);
	localparam int row_w = $clog2(`CNN_IMG_DIM);
	localparam int k_w = $clog2(`CNN_K_DIM);
	localparam int tap_w = $clog2(`CNN_K_DIM*`CNN_K_DIM);
	localparam int idx_w = $clog2(`CNN_OUT_DIM*`CNN_OUT_DIM);
	localparam int out_last = `CNN_OUT_DIM - 1;
	localparam int k_last = `CNN_K_DIM - 1;
	localparam logic signed [`CNN_ACC_W-1:0] sat_max = (1 <<< (`CNN_RES_W - 1)) - 1;

	cnn_pkg::conv_state_e state;
	logic [row_w-1:0] out_row;
	logic [row_w-1:0] out_col;
	logic [k_w-1:0] k_row;
	logic [k_w-1:0] k_col;
	logic signed [`CNN_ACC_W-1:0] acc;
	logic signed [2*`CNN_PIX_W-1:0] product;
	logic signed [`CNN_ACC_W-1:0] biased;
	logic last_tap;
	logic last_output;

	assign pixel_row = out_row + row_w'(k_row);
	assign pixel_col = out_col + row_w'(k_col);
	assign tap = tap_w'(k_row * `CNN_K_DIM + k_col);
	assign last_tap = (k_row == k_last) && (k_col == k_last);
	assign last_output = (out_row == out_last) && (out_col == out_last);

	assign product = pixel_value * weight_value;
	assign biased = acc + bias_value;

	// relu then clamp to the result width
	always_comb
	begin
		if (biased[`CNN_ACC_W-1])
			result.save_data = '0;
		else if (biased > sat_max)
			result.save_data = sat_max[`CNN_RES_W-1:0];
		else
			result.save_data = biased[`CNN_RES_W-1:0];
	end

	assign result.save_enable = (state == cnn_pkg::state_save);
	assign result.save_index = idx_w'(out_row * `CNN_OUT_DIM + out_col);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= cnn_pkg::state_idle;
			result.calculation_done <= 1'b0;
			out_row <= '0;
			out_col <= '0;
			k_row <= '0;
			k_col <= '0;
		end
		else
		begin
			result.calculation_done <= 1'b0;
			case (state)
				cnn_pkg::state_idle:
				begin
					out_row <= '0;
					out_col <= '0;
					k_row <= '0;
					k_col <= '0;
					if (start)
						state <= cnn_pkg::state_accumulate;
				end
				cnn_pkg::state_accumulate:
				begin
					k_col <= (k_col == k_last) ? '0 : k_col + 1'b1;
					if (k_col == k_last)
						k_row <= (k_row == k_last) ? '0 : k_row + 1'b1;
					if (last_tap)
						state <= cnn_pkg::state_save;
				end
				cnn_pkg::state_save:
				begin
					out_col <= (out_col == out_last) ? '0 : out_col + 1'b1;
					if (out_col == out_last)
						out_row <= (out_row == out_last) ? '0 : out_row + 1'b1;
					if (last_output)
					begin
						state <= cnn_pkg::state_idle;
						result.calculation_done <= 1'b1;
					end
					else
						state <= cnn_pkg::state_accumulate;
				end
				default: state <= cnn_pkg::state_idle;
			endcase
		end
	end

	// fresh sum for every output
	always_ff @(posedge clk)
	begin
		if (state == cnn_pkg::state_accumulate)
			acc <= acc + product;
		else
			acc <= '0;
	end

endmodule

// File: rtl/result_store.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module result_store (
	input logic clk,
	input logic rst,
	input logic [31:0] araddr,
	input logic arvalid,
	input logic clear_interrupt,
	result_save_if.sink result,
	output logic [31:0] rdata,
	output logic interrupt_signal
);
	localparam int result_count = `CNN_OUT_DIM * `CNN_OUT_DIM;
	localparam int idx_w = $clog2(result_count);

	logic [`CNN_RES_W-1:0] result_mem [result_count];
	logic read_hit;

	// anything outside the result window reads as zero
	assign read_hit = ((araddr & `CNN_REGION_MASK) == `CNN_RESULT_BASE)
		&& (araddr[27:0] < result_count);

	always_ff @(posedge clk)
	begin
		if (result.save_enable)
			result_mem[result.save_index] <= result.save_data;
		if (arvalid)
			rdata <= read_hit
				? {{(32-`CNN_RES_W){1'b0}}, result_mem[araddr[idx_w-1:0]]}
				: 32'd0;
	end

	// done has priority over a clear in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			interrupt_signal <= 1'b0;
		else if (result.calculation_done)
			interrupt_signal <= 1'b1;
		else if (clear_interrupt)
			interrupt_signal <= 1'b0;
	end

endmodule

// File: rtl/cnn.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module cnn (
	input logic clk,
	input logic rst,
	input logic [31:0] araddr,
	input logic arvalid,
	input logic [31:0] awaddr,
	input logic awvalid,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic [31:0] rdata,
	output logic interrupt_signal
);
	logic start;
	logic clear_interrupt;
	logic [$clog2(`CNN_IMG_DIM)-1:0] pixel_row;
	logic [$clog2(`CNN_IMG_DIM)-1:0] pixel_col;
	logic [$clog2(`CNN_K_DIM*`CNN_K_DIM)-1:0] tap;
	logic signed [`CNN_PIX_W-1:0] pixel_value;
	logic signed [`CNN_PIX_W-1:0] weight_value;
	logic signed [`CNN_RES_W-1:0] bias_value;

	store_write_if store_bus ();
	result_save_if result_bus ();

	bus_write_decoder i_decoder (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.wdata(wdata),
		.wvalid(wvalid),
		.store(store_bus),
		.start(start),
		.clear_interrupt(clear_interrupt)
	);

	feature_store i_feature_store (
		.clk(clk),
		.store(store_bus),
		.pixel_row(pixel_row),
		.pixel_col(pixel_col),
		.tap(tap),
		.pixel_value(pixel_value),
		.weight_value(weight_value),
		.bias_value(bias_value)
	);

	conv_engine i_conv_engine (
		.clk(clk),
		.rst(rst),
		.start(start),
		.pixel_value(pixel_value),
		.weight_value(weight_value),
		.bias_value(bias_value),
		.pixel_row(pixel_row),
		.pixel_col(pixel_col),
		.tap(tap),
		.result(result_bus)
	);

	result_store i_result_store (
		.clk(clk),
		.rst(rst),
		.araddr(araddr),
		.arvalid(arvalid),
		.clear_interrupt(clear_interrupt),
		.result(result_bus),
		.rdata(rdata),
		.interrupt_signal(interrupt_signal)
	);

endmodule

// File: verification/cnn_sva.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module cnn_sva (
	input logic clk,
	input logic rst,
	input logic engine_idle,
	input logic save_enable,
	input logic [$clog2(`CNN_OUT_DIM*`CNN_OUT_DIM)-1:0] save_index,
	input logic calculation_done,
	input logic interrupt_signal
);
	localparam int out_count = `CNN_OUT_DIM * `CNN_OUT_DIM;

	// read by the testbench at the end of the run
	int failures = 0;

	save_low_in_idle: assert property (@(posedge clk) disable iff (rst)
		engine_idle |-> !save_enable)
		else
		begin
			failures++;
			$error("save_enable high while the engine is idle");
		end

	save_index_range: assert property (@(posedge clk) disable iff (rst)
		save_enable |-> (save_index < out_count))
		else
		begin
			failures++;
			$error("save_index outside the result memory");
		end

	done_single_pulse: assert property (@(posedge clk) disable iff (rst)
		calculation_done |=> !calculation_done)
		else
		begin
			failures++;
			$error("calculation_done held for more than one cycle");
		end

	interrupt_after_reset: assert property (@(posedge clk) rst |=> !interrupt_signal)
		else
		begin
			failures++;
			$error("interrupt high in the cycle after reset");
		end
endmodule

// engine side has no interrupt, result side has no state
bind conv_engine cnn_sva i_engine_sva (
	.clk(clk),
	.rst(rst),
	.engine_idle(state == cnn_pkg::state_idle),
	.save_enable(result.save_enable),
	.save_index(result.save_index),
	.calculation_done(result.calculation_done),
	.interrupt_signal(1'b0)
);

bind result_store cnn_sva i_result_sva (
	.clk(clk),
	.rst(rst),
	.engine_idle(1'b0),
	.save_enable(result.save_enable),
	.save_index(result.save_index),
	.calculation_done(result.calculation_done),
	.interrupt_signal(interrupt_signal)
);

// File: verification/cnn_tb.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module cnn_tb;
	localparam int clk_period = 100;
	localparam int drive_delay = 5;
	localparam int reset_cycles = 10;
	localparam int test_count = 6;
	localparam int pixel_count = `CNN_IMG_DIM * `CNN_IMG_DIM;
	localparam int tap_count = `CNN_K_DIM * `CNN_K_DIM;
	localparam int out_count = `CNN_OUT_DIM * `CNN_OUT_DIM;
	localparam int write_cycles = 2 * (pixel_count + tap_count + 4);
	localparam int read_cycles = 2 * (out_count + 1);
	localparam int watchdog_cycles = reset_cycles
		+ test_count * (500 + write_cycles + read_cycles);
	// start write edge to interrupt rising
	localparam int start_latency = 363;
	localparam logic [1:0] fill_random = 2'd0;
	localparam logic [1:0] fill_max = 2'd1;
	localparam logic [1:0] fill_min = 2'd2;

	typedef struct packed {
		logic [71:0] kernel;
		logic signed [15:0] bias;
		logic [1:0] fill;
		logic rand_params;
		logic mid_start;
	} test_entry_t;

	logic clk;
	logic rst;
	logic [31:0] araddr;
	logic arvalid;
	logic [31:0] awaddr;
	logic awvalid;
	logic [31:0] wdata;
	logic wvalid;
	logic [31:0] rdata;
	logic interrupt_signal;

	test_entry_t tests [test_count];
	logic signed [7:0] pix_model [pixel_count];
	logic signed [7:0] kernel_model [tap_count];
	logic signed [15:0] bias_model;

	cnn i_cnn (
		.clk(clk),
		.rst(rst),
		.araddr(araddr),
		.arvalid(arvalid),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.wdata(wdata),
		.wvalid(wvalid),
		.rdata(rdata),
		.interrupt_signal(interrupt_signal)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: the tests did not finish in %0d cycles", watchdog_cycles);
		$display("Verification failed");
		$fatal(1, "run stopped by the watchdog");
	end

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, actual, expected);
			$display("Verification failed");
			$fatal(1, "mismatch in %s", what);
		end
	endtask

	// failures flagged by the bound checkers
	function automatic int assertion_failures();
		return i_cnn.i_conv_engine.i_engine_sva.failures
			+ i_cnn.i_result_store.i_result_sva.failures;
	endfunction

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		#drive_delay;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(posedge clk);
		#drive_delay;
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
		@(posedge clk);
		#drive_delay;
		araddr = addr;
		arvalid = 1'b1;
		@(posedge clk);
		#drive_delay;
		arvalid = 1'b0;
		data = rdata;
	endtask

	// convolution, bias, relu and 16-bit clamp
	function automatic int expected_output(input int row, input int col);
		int sum;
		sum = 0;
		for (int kr = 0; kr < `CNN_K_DIM; kr++)
			for (int kc = 0; kc < `CNN_K_DIM; kc++)
				sum += int'(pix_model[(row + kr) * `CNN_IMG_DIM + col + kc])
					* int'(kernel_model[kr * `CNN_K_DIM + kc]);
		sum += int'(bias_model);
		if (sum < 0)
			return 0;
		if (sum > 32767)
			return 32767;
		return sum;
	endfunction

	task automatic load_stores(input test_entry_t entry);
		for (int i = 0; i < pixel_count; i++)
		begin
			case (entry.fill)
				fill_max: pix_model[i] = 8'sd127;
				fill_min: pix_model[i] = -8'sd128;
				default: pix_model[i] = 8'($urandom);
			endcase
			bus_write(`CNN_PIXEL_BASE + i, {24'h0, pix_model[i]});
		end
		for (int t = 0; t < tap_count; t++)
		begin
			kernel_model[t] = entry.rand_params ? 8'($urandom) : entry.kernel[t*8 +: 8];
			bus_write(`CNN_WEIGHT_BASE + t, {24'h0, kernel_model[t]});
		end
		bias_model = entry.rand_params ? 16'(int'($urandom % 4001) - 2000) : entry.bias;
		bus_write(`CNN_BIAS_BASE, {16'h0, bias_model});
	endtask

	task automatic run_entry(input int n);
		time start_time;
		int cycles;
		logic [31:0] value;
		load_stores(tests[n]);
		bus_write(`CNN_CTRL_BASE, 32'h1);
		start_time = $time;
		check_value($sformatf("test %0d interrupt before done", n), interrupt_signal, 0);
		// a restart here would push the interrupt out
		if (tests[n].mid_start)
		begin
			repeat (100) @(posedge clk);
			bus_write(`CNN_CTRL_BASE, 32'h1);
		end
		while (!interrupt_signal)
		begin
			@(posedge clk);
			#drive_delay;
		end
		// counted up to the edge that samples the interrupt high
		cycles = int'(($time - start_time) / clk_period) + 1;
		check_value($sformatf("test %0d interrupt latency", n), cycles, start_latency);
		for (int i = 0; i < out_count; i++)
		begin
			bus_read(`CNN_RESULT_BASE + i, value);
			check_value($sformatf("test %0d result %0d", n, i), value,
				expected_output(i / `CNN_OUT_DIM, i % `CNN_OUT_DIM));
		end
		bus_read(`CNN_RESULT_BASE + 40, value);
		check_value($sformatf("test %0d result 40", n), value, 0);
		check_value($sformatf("test %0d interrupt held", n), interrupt_signal, 1);
		bus_write(`CNN_CTRL_BASE, 32'h2);
		@(posedge clk);
		#drive_delay;
		check_value($sformatf("test %0d interrupt cleared", n), interrupt_signal, 0);
	endtask

	initial
	begin
		void'($urandom(32'h008a_e25d));
		rst = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		// centre tap is tap 4, bits 39:32
		tests[0] = '{72'h00_0000_0001_0000_0000, 16'sd0, fill_random, 1'b0, 1'b0};
		tests[1] = '{{9{8'hff}}, 16'sd0, fill_random, 1'b0, 1'b0};
		tests[2] = '{{9{8'h7f}}, 16'sd20000, fill_max, 1'b0, 1'b0};
		tests[3] = '{{9{8'h80}}, -16'sd1000, fill_min, 1'b0, 1'b0};
		tests[4] = '{72'h0, 16'sd0, fill_random, 1'b1, 1'b0};
		tests[5] = '{72'h0, 16'sd0, fill_random, 1'b1, 1'b1};
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		rst = 1'b0;
		check_value("interrupt after reset", interrupt_signal, 0);
		for (int n = 0; n < test_count; n++)
			run_entry(n);
		if (assertion_failures() == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end
endmodule

// File: tb.f
+incdir+rtl
rtl/cnn_pkg.sv
rtl/cnn_ifs.sv
rtl/bus_write_decoder.sv
rtl/feature_store.sv
rtl/conv_engine.sv
rtl/result_store.sv
rtl/cnn.sv
verification/cnn_sva.sv
verification/cnn_tb.sv
